//--- all.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/insn_mem.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/alu.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/riscv_core_top.sv
sim/tb_core.sv

//--- Bender.yml
package:
  name: riscv_core

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/insn_mem.sv
      - hdl/reg_file.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/alu.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/riscv_core_top.sv
  - target: simulation
    files:
      - sim/tb_core.sv

//--- sim/core_stimulus.txt
# P word_addr insn           (program word, hex)
# E pc insn status we rd data (expected writeback trace per cycle, hex)
P 00 800000B7
P 01 FFB00113
P 02 40115193
P 03 0020A233
P 04 0020B2B3
P 05 40120333
P 06 00534033
P 07 004353B3
P 08 0043E433
P 09 00720463
P 0A 00520463
P 0B 00148493
P 0C 00521463
P 0D 00721463
P 0E 00148493
P 0F 00124463
P 10 0040C463
P 11 00148493
P 12 0040D463
P 13 00125463
P 14 00148493
P 15 0040E463
P 16 00126463
P 17 00148493
P 18 0020F463
P 19 00117463
P 1A 00148493
P 1B 00000073
E 00000000 00000000 1 0 00 00000000
E 00000000 00000000 1 0 00 00000000
E 00000000 00000000 1 0 00 00000000
E 00000000 00000000 1 0 00 00000000
E 00000000 800000B7 2 1 01 80000000
E 00000004 FFB00113 2 1 02 FFFFFFFB
E 00000008 40115193 2 1 03 FFFFFFFD
E 0000000C 0020A233 2 1 04 00000001
E 00000010 0020B2B3 2 1 05 00000001
E 00000014 40120333 2 1 06 80000001
E 00000018 00534033 2 0 00 00000000
E 0000001C 004353B3 2 1 07 40000000
E 00000020 0043E433 2 1 08 40000001
E 00000024 00720463 2 0 00 00000000
E 00000028 00520463 2 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000030 00521463 2 0 00 00000000
E 00000034 00721463 2 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 0000003C 00124463 2 0 00 00000000
E 00000040 0040C463 2 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000048 0040D463 2 0 00 00000000
E 0000004C 00125463 2 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000054 0040E463 2 0 00 00000000
E 00000058 00126463 2 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000060 0020F463 2 0 00 00000000
E 00000064 00117463 2 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 00000000 00000000 4 0 00 00000000
E 0000006C 00000073 2 0 00 00000000

//--- sim/tb_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_core import rv_pkg::*; ();

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 16;
  localparam int    SLACK_CYCLES = 50;
  localparam string STIM_FILE    = "sim/core_stimulus.txt";

  logic       clk;
  logic       rst;
  imem_load_t load;
  logic       halt;
  wb_trace_t  trace;

  imem_load_t prog_q[$];
  wb_trace_t  exp_q[$];
  logic       stim_ready;

  riscv_core_top UUT (
    .clk   (clk),
    .rst   (rst),
    .load  (load),
    .halt  (halt),
    .trace (trace)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input cycle_status_e got,
                              input cycle_status_e exp);
    if (got !== exp) begin
      report_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // rd and data only matter when the write is enabled
  task automatic check_write(input string name, input rd_write_t got, input rd_write_t exp);
    if (got.we !== exp.we) begin
      report_failure($sformatf("[ERROR] %s.we: got %h, expected %h", name, got.we, exp.we));
    end else if (exp.we) begin
      if (got.rd !== exp.rd) begin
        report_failure($sformatf("[ERROR] %s.rd: got %h, expected %h",
                                 name, got.rd, exp.rd));
      end
      if (got.data !== exp.data) begin
        report_failure($sformatf("[ERROR] %s.data: got %h, expected %h",
                                 name, got.data, exp.data));
      end
    end
  endtask

  task automatic read_stimulus();
    int               fd;
    int               n;
    string            line;
    byte              kind;
    logic [`XLEN-1:0] f0, f1, f2, f3, f4, f5;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      report_failure("could not open the stimulus file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() == 0) begin
        continue;
      end
      kind = line.getc(0);
      if (kind == "P") begin
        n = $sscanf(line, "P %h %h", f0, f1);
        if (n != 2) begin
          report_failure({"malformed program line in stimulus file: ", line});
        end
        prog_q.push_back('{en: 1'b1, addr: f0[`IMEM_ADDR_W-1:0], data: f1});
      end else if (kind == "E") begin
        n = $sscanf(line, "E %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
        if (n != 6) begin
          report_failure({"malformed expected line in stimulus file: ", line});
        end
        exp_q.push_back('{pc: f0, insn: f1, cycle_status: cycle_status_e'(f2[2:0]),
                          write: '{we: f3[0], rd: f4[`REG_ADDR_W-1:0], data: f5}});
      end
    end
    $fclose(fd);
  endtask

  // halt is expected exactly when a plain ecall sits in writeback
  task automatic compare_trace(input int idx);
    wb_trace_t exp;
    exp = exp_q[idx];
    check_word("trace.pc", trace.pc, exp.pc);
    check_word("trace.insn", trace.insn, exp.insn);
    check_status("trace.cycle_status", trace.cycle_status, exp.cycle_status);
    check_write("trace.write", trace.write, exp.write);
    check_bit("halt", halt, exp.insn == 32'h0000_0073);
  endtask

  initial begin
    int cyc;
    rst        = 1'b1;
    load       = '0;
    stim_ready = 1'b0;
    read_stimulus();
    stim_ready = 1'b1;
    cyc = 0;
    // program goes in while the core is held in reset
    foreach (prog_q[i]) begin
      @(posedge clk);
      load <= prog_q[i];
      cyc++;
    end
    @(posedge clk);
    load <= '0;
    cyc++;
    while (cyc < RESET_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    @(posedge clk);
    rst <= 1'b0;
    // one expected line per cycle, sampled mid-cycle
    foreach (exp_q[i]) begin
      @(negedge clk);
      compare_trace(i);
    end
    if (halt === 1'b1) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_failure("expected trace ended without the core halting");
    end
  end

  initial begin
    int limit;
    wait (stim_ready);
    limit = prog_q.size() + exp_q.size() + RESET_CYCLES + SLACK_CYCLES;
    #(limit * CLK_PERIOD);
    report_failure("run did not finish before the watchdog expired");
  end

endmodule

//--- hdl/riscv_core_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module riscv_core_top import rv_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  imem_load_t load,
  output logic       halt,
  output wb_trace_t  trace
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] insn;
  decode_state_t    decode_state;
  execute_state_t   execute_state;
  redirect_t        redirect;
  pipe_state_t      mem_state;
  rd_write_t        wb_write;

  insn_mem u_insn_mem (
    .clk  (clk),
    .load (load),
    .pc   (pc),
    .insn (insn)
  );

  fetch_stage u_fetch (
    .clk          (clk),
    .rst          (rst),
    .redirect     (redirect),
    .insn         (insn),
    .pc           (pc),
    .decode_state (decode_state)
  );

  decode_stage u_decode (
    .clk           (clk),
    .rst           (rst),
    .decode_state  (decode_state),
    .redirect      (redirect),
    .wb_write      (wb_write),
    .execute_state (execute_state)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst           (rst),
    .execute_state (execute_state),
    .wb_write      (wb_write),
    .redirect      (redirect),
    .mem_state     (mem_state)
  );

  writeback_stage u_writeback (
    .clk       (clk),
    .rst       (rst),
    .mem_state (mem_state),
    .wb_write  (wb_write),
    .halt      (halt),
    .trace     (trace)
  );

endmodule

//--- hdl/writeback_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module writeback_stage import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  pipe_state_t mem_state,
  output rd_write_t   wb_write,
  output logic        halt,
  output wb_trace_t   trace
);

  pipe_state_t wb_state;

  // memory stage has no work of its own, just pass it on
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_state <= '{cycle_status: CYCLE_RESET, default: '0};
    end else begin
      wb_state <= mem_state;
    end
  end

  assign wb_write = wb_state.write;

  // ecall only, ebreak and csr forms do not halt
  assign halt = (wb_state.insn[6:0] == OPC_SYSTEM) && (wb_state.insn[31:7] == '0);

  assign trace = '{
    pc:           wb_state.pc,
    insn:         wb_state.insn,
    cycle_status: wb_state.cycle_status,
    write:        wb_state.write
  };

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_stage import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  execute_state_t execute_state,
  input  rd_write_t      wb_write,
  output redirect_t      redirect,
  output pipe_state_t    mem_state
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] result;
  logic             branch_taken;
  logic [`XLEN-1:0] target;
  logic             valid;
  logic             writes_rd;
  opcode_e          opcode;

  // memory stage is younger than writeback, so it wins
  function automatic logic [`XLEN-1:0] bypass(
    input logic [`REG_ADDR_W-1:0] idx,
    input logic [`XLEN-1:0]       reg_val,
    input rd_write_t              m_wr,
    input rd_write_t              w_wr
  );
    if (m_wr.we && m_wr.rd == idx) begin
      return m_wr.data;
    end else if (w_wr.we && w_wr.rd == idx) begin
      return w_wr.data;
    end
    return reg_val;
  endfunction

  assign op_a = bypass(execute_state.rs1, execute_state.rs1_data, mem_state.write, wb_write);
  assign op_b = bypass(execute_state.rs2, execute_state.rs2_data, mem_state.write, wb_write);

  alu u_alu (
    .insn         (execute_state.insn),
    .pc           (execute_state.pc),
    .op_a         (op_a),
    .op_b         (op_b),
    .result       (result),
    .branch_taken (branch_taken),
    .target       (target)
  );

  assign valid  = (execute_state.cycle_status == CYCLE_NO_STALL);
  assign opcode = opcode_e'(execute_state.insn[6:0]);
  assign writes_rd = (opcode == OPC_LUI) || (opcode == OPC_OP_IMM) || (opcode == OPC_OP);

  assign redirect = '{taken: valid && branch_taken, target: target};

  // execute-to-memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_state <= '{cycle_status: CYCLE_RESET, default: '0};
    end else begin
      mem_state.pc           <= execute_state.pc;
      mem_state.insn         <= execute_state.insn;
      mem_state.cycle_status <= execute_state.cycle_status;
      mem_state.write.we     <= valid && writes_rd && execute_state.rd != '0;
      mem_state.write.rd     <= execute_state.rd;
      mem_state.write.data   <= result;
    end
  end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module alu import rv_pkg::*; (
  input  logic [`XLEN-1:0] insn,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] op_a,
  input  logic [`XLEN-1:0] op_b,
  output logic [`XLEN-1:0] result,
  output logic             branch_taken,
  output logic [`XLEN-1:0] target
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] src_b;
  logic [4:0]       shamt;
  logic             sub_en;
  logic [`XLEN-1:0] alu_out;
  logic             cond;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  // register-register uses rs2, everything else the I immediate
  assign src_b  = (opcode == OPC_OP) ? op_b : imm_i;
  assign shamt  = src_b[4:0];
  // bit 30 of an addi immediate is not a subtract
  assign sub_en = (opcode == OPC_OP) && insn[30];

  always_comb begin
    case (funct3)
      3'b000:  alu_out = sub_en ? op_a - src_b : op_a + src_b;
      3'b001:  alu_out = op_a << shamt;
      3'b010:  alu_out = {31'b0, $signed(op_a) < $signed(src_b)};
      3'b011:  alu_out = {31'b0, op_a < src_b};
      3'b100:  alu_out = op_a ^ src_b;
      // srai/sra share funct7 bit 30
      3'b101:  alu_out = insn[30] ? `XLEN'($signed(op_a) >>> shamt) : op_a >> shamt;
      3'b110:  alu_out = op_a | src_b;
      default: alu_out = op_a & src_b;
    endcase
  end

  always_comb begin
    case (opcode)
      OPC_LUI:    result = imm_u;
      OPC_OP_IMM: result = alu_out;
      OPC_OP:     result = alu_out;
      default:    result = '0;
    endcase
  end

  // branch compare
  always_comb begin
    case (funct3)
      3'b000:  cond = (op_a == op_b);
      3'b001:  cond = (op_a != op_b);
      3'b100:  cond = $signed(op_a) < $signed(op_b);
      3'b101:  cond = $signed(op_a) >= $signed(op_b);
      3'b110:  cond = op_a < op_b;
      3'b111:  cond = op_a >= op_b;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = (opcode == OPC_BRANCH) && cond;
  assign target       = pc + imm_b;

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_stage import rv_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  decode_state_t  decode_state,
  input  redirect_t      redirect,
  input  rd_write_t      wb_write,
  output execute_state_t execute_state
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       rf_rs1_data;
  logic [`XLEN-1:0]       rf_rs2_data;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  assign rs1 = decode_state.insn[19:15];
  assign rs2 = decode_state.insn[24:20];
  assign rd  = decode_state.insn[11:7];

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .write    (wb_write)
  );

  // writeback lands this cycle, so take it ahead of the array
  assign rs1_data = (wb_write.we && wb_write.rd == rs1) ? wb_write.data : rf_rs1_data;
  assign rs2_data = (wb_write.we && wb_write.rd == rs2) ? wb_write.data : rf_rs2_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{cycle_status: CYCLE_RESET, default: '0};
    end else if (redirect.taken) begin
      execute_state <= '{cycle_status: CYCLE_TAKEN_BRANCH, default: '0};
    end else begin
      execute_state <= '{
        pc:           decode_state.pc,
        insn:         decode_state.insn,
        rs1:          rs1,
        rs2:          rs2,
        rd:           rd,
        rs1_data:     rs1_data,
        rs2_data:     rs2_data,
        cycle_status: decode_state.cycle_status
      };
    end
  end

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module fetch_stage import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  redirect_t        redirect,
  input  logic [`XLEN-1:0] insn,
  output logic [`XLEN-1:0] pc,
  output decode_state_t    decode_state
);

  logic [`XLEN-1:0] pc_next;

  // branch target wins over sequential fetch
  assign pc_next = redirect.taken ? redirect.target : pc + `XLEN'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // fetch-to-decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_state <= '{pc: '0, insn: '0, cycle_status: CYCLE_RESET};
    end else if (redirect.taken) begin
      // wrong-path fetch squashed
      decode_state <= '{pc: '0, insn: '0, cycle_status: CYCLE_TAKEN_BRANCH};
    end else begin
      decode_state <= '{pc: pc, insn: insn, cycle_status: CYCLE_NO_STALL};
    end
  end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  rd_write_t              write
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write.we && write.rd != '0) begin
      regs[write.rd] <= write.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/insn_mem.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module insn_mem import rv_pkg::*; (
  input  logic             clk,
  input  imem_load_t       load,
  input  logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] insn
);

  logic [`XLEN-1:0] mem [`IMEM_WORDS];
  logic [`IMEM_ADDR_W-1:0] fetch_idx;

  // program load, one word per clock
  always_ff @(posedge clk) begin
    if (load.en) begin
      mem[load.addr] <= load.data;
    end
  end

  // byte pc to word index
  assign fetch_idx = pc[`IMEM_ADDR_W+1:2];

  // no clock on the read side
  assign insn = mem[fetch_idx];

endmodule

//--- hdl/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

  // major opcodes of the supported subset
  typedef enum logic [`OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // what occupies Writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  typedef struct packed {
    logic                    en;
    logic [`IMEM_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]        data;
  } imem_load_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] insn;
    cycle_status_e    cycle_status;
  } decode_state_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       insn;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    cycle_status_e          cycle_status;
  } execute_state_t;

  // register write, also the forwarding record
  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } rd_write_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] insn;
    cycle_status_e    cycle_status;
    rd_write_t        write;
  } pipe_state_t;

  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] insn;
    cycle_status_e    cycle_status;
    rd_write_t        write;
  } wb_trace_t;

endpackage

//--- hdl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and register file
`define XLEN 32
`define NUM_REGS 32
`define REG_ADDR_W 5

// instruction memory, word addressed
`define IMEM_WORDS 256
`define IMEM_ADDR_W 8

`define RESET_PC 32'h0000_0000
`define OPCODE_W 7

`endif
